// ==== Makefile ====
# Verilator build and run of the sdram command path testbench

VERILATOR ?= verilator
TOP       ?= tb_sdram_ctrl_top
FILELIST  ?= sdram_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the output for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/sdram_cmd_issue.sv ====
`timescale 1ns/10ps
// sdram issue stage driving command pins and spacing commands by their minimum gap
module sdram_cmd_issue #(
    parameter real CLK_PERIOD = 7.0 // ns
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  sdram_cmd_pkg::sdram_cmd_t issue_cmd,
    input  logic                      issue_cmd_valid,
    output logic                      issue_cmd_ready,
    output logic                      sdram_cs_n,
    output logic                      sdram_ras_n,
    output logic                      sdram_cas_n,
    output logic                      sdram_we_n,
    output logic [1:0]                sdram_ba,
    output logic [15:0]               sdram_addr
);
    import sdram_cmd_pkg::*;

    // gaps in cycles, at least one
    localparam int CYC_RP  = ns_to_cycles(T_RP_NS, CLK_PERIOD);
    localparam int CYC_MRD = ns_to_cycles(T_MRD_NS, CLK_PERIOD);
    localparam int CYC_RFC = ns_to_cycles(T_RFC_NS, CLK_PERIOD);
    localparam int CYC_RCD = ns_to_cycles(T_RCD_NS, CLK_PERIOD);
    localparam int GAP_RP  = (CYC_RP > 1) ? CYC_RP : 1;
    localparam int GAP_MRD = (CYC_MRD > 1) ? CYC_MRD : 1;
    localparam int GAP_RFC = (CYC_RFC > 1) ? CYC_RFC : 1;
    localparam int GAP_RCD = (CYC_RCD > 1) ? CYC_RCD : 1;
    localparam int GAP_M1  = (GAP_RP > GAP_MRD) ? GAP_RP : GAP_MRD;
    localparam int GAP_M2  = (GAP_RFC > GAP_RCD) ? GAP_RFC : GAP_RCD;
    localparam int GAP_MAX = (GAP_M1 > GAP_M2) ? GAP_M1 : GAP_M2;
    localparam int GAP_W   = $clog2(GAP_MAX + 1);

    logic [GAP_W-1:0] gap_cnt;  // cycles left before ready returns
    logic [GAP_W-1:0] gap_load;
    logic [2:0]       rcw;      // ras_n, cas_n, we_n for the incoming code
    logic             xfer;

    assign xfer            = issue_cmd_valid & issue_cmd_ready;
    assign issue_cmd_ready = (gap_cnt == '0);

    // pin levels and spacing per code
    always_comb
    begin
        case (issue_cmd.code)
            PRECHARGE:
            begin
                rcw      = 3'b010;
                gap_load = GAP_W'(GAP_RP - 1);
            end
            MR_SET:
            begin
                rcw      = 3'b000;
                gap_load = GAP_W'(GAP_MRD - 1);
            end
            AUTO_REFRESH:
            begin
                rcw      = 3'b001;
                gap_load = GAP_W'(GAP_RFC - 1);
            end
            ACTIVE:
            begin
                rcw      = 3'b011;
                gap_load = GAP_W'(GAP_RCD - 1);
            end
            READ:
            begin
                rcw      = 3'b101;
                gap_load = GAP_W'(GAP_RCD - 1);
            end
            WRITE:
            begin
                rcw      = 3'b100;
                gap_load = GAP_W'(GAP_RCD - 1);
            end
            default:
            begin
                rcw      = 3'b111; // nop just burns its slot
                gap_load = '0;
            end
        endcase
    end

    // gap counter and control pins
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gap_cnt     <= '0;
            sdram_cs_n  <= 1'b1; // deselect
            sdram_ras_n <= 1'b1;
            sdram_cas_n <= 1'b1;
            sdram_we_n  <= 1'b1;
        end
        else
        begin
            if (xfer)
                gap_cnt <= gap_load;
            else if (gap_cnt != '0)
                gap_cnt <= gap_cnt - 1'b1;

            if (xfer && issue_cmd.code != NOP)
            begin
                sdram_cs_n                              <= 1'b0; // one cycle only
                {sdram_ras_n, sdram_cas_n, sdram_we_n} <= rcw;
            end
            else
            begin
                sdram_cs_n                              <= 1'b1;
                {sdram_ras_n, sdram_cas_n, sdram_we_n} <= 3'b111;
            end
        end
    end

    // bank and address follow the accepted command, a nop leaves them alone
    always_ff @(posedge clk)
    begin
        if (xfer && issue_cmd.code != NOP)
        begin
            sdram_ba   <= issue_cmd.ba;
            sdram_addr <= issue_cmd.addr.row_col; // plain view onto the pins
        end
    end

    // inside a gap only the first cycle may carry a command
    a_one_cmd_per_gap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (gap_cnt != '0) && $past(gap_cnt != '0) |-> sdram_cs_n
    );

endmodule

// ==== hdl/sdram_cmd_pkg.sv ====
// sdram command path definitions for command word layout, codes and minimum timing
package sdram_cmd_pkg;

    // logical command codes carried in the low bits of a command word
    typedef enum logic [2:0] {
        PRECHARGE    = 3'b001,
        WRITE        = 3'b010,
        ACTIVE       = 3'b011,
        MR_SET       = 3'b100,
        AUTO_REFRESH = 3'b101,
        READ         = 3'b110,
        NOP          = 3'b111
    } sdram_cmd_code_e;

    // mode register layout as seen on the address pins during MR_SET
    typedef struct packed {
        logic [5:0] reserved;      // must be zero
        logic       wr_burst_mode; // 0 = programmed burst
        logic [1:0] op_mode;       // 00 = standard operation
        logic [2:0] cas_latency;
        logic       burst_type;    // 0 = sequential
        logic [2:0] burst_len;     // 111 = full page
    } sdram_mode_reg_t;

    // one address word, two readings
    typedef union packed {
        logic [15:0]     row_col; // row/column, bit 10 = all banks on precharge
        sdram_mode_reg_t mode;    // only meaningful with MR_SET
    } sdram_addr_u;

    // stream payload, 24 bits
    typedef struct packed {
        logic [2:0]      reserved;
        logic [1:0]      ba;   // bank select
        sdram_addr_u     addr;
        sdram_cmd_code_e code;
    } sdram_cmd_t;

    // minimum spacing after each command class, in ns
    localparam real T_RP_NS  = 18.0; // precharge to next command
    localparam real T_MRD_NS = 15.0; // mode register set
    localparam real T_RFC_NS = 66.0; // auto refresh cycle time
    localparam real T_RCD_NS = 18.0; // everything else

    // ceiling of t_ns / clk_ns
    function automatic int ns_to_cycles(input real t_ns, input real clk_ns);
        int  n;
        real q;
        q = t_ns / clk_ns;
        n = int'(q);      // rounds to nearest
        if (real'(n) < q)
            n = n + 1;    // rounded down, push up
        return n;
    endfunction

endpackage

// ==== hdl/sdram_cmd_sched.sv ====
`timescale 1ns/10ps
// sdram command scheduler merging init, periodic refresh and user streams
module sdram_cmd_sched #(
    parameter real CLK_PERIOD       = 7.0,    // ns
    parameter real REFRESH_INTERVAL = 7800.0  // ns between refreshes
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      init_done,
    input  sdram_cmd_pkg::sdram_cmd_t init_cmd,
    input  logic                      init_cmd_valid,
    output logic                      init_cmd_ready,
    input  sdram_cmd_pkg::sdram_cmd_t user_cmd,
    input  logic                      user_cmd_valid,
    output logic                      user_cmd_ready,
    output sdram_cmd_pkg::sdram_cmd_t issue_cmd,
    output logic                      issue_cmd_valid,
    input  logic                      issue_cmd_ready
);
    import sdram_cmd_pkg::*;

    localparam int REF_P = ns_to_cycles(REFRESH_INTERVAL, CLK_PERIOD); // interval in cycles
    localparam int REF_W = $clog2(REF_P + 1);

    logic [REF_W-1:0] ref_cnt;   // runs freely once init is done
    logic             ref_pend;  // refresh owed to the array
    logic             user_hold; // user command on the bus, not yet taken
    logic             sel_ref;   // refresh owns the issue stream
    logic             ref_xfer;

    // a user command already shown keeps the bus until it goes
    assign sel_ref  = init_done & ref_pend & ~user_hold;
    assign ref_xfer = sel_ref & issue_cmd_ready;

    // source select, no register on this path
    always_comb
    begin
        issue_cmd       = init_cmd;
        issue_cmd_valid = 1'b0;
        init_cmd_ready  = 1'b0;
        user_cmd_ready  = 1'b0;
        if (!init_done)
        begin
            issue_cmd_valid = init_cmd_valid; // init sequence only
            init_cmd_ready  = issue_cmd_ready;
        end
        else if (sel_ref)
        begin
            issue_cmd       = '0;
            issue_cmd.code  = AUTO_REFRESH; // self-built
            issue_cmd_valid = 1'b1;
        end
        else
        begin
            issue_cmd       = user_cmd;
            issue_cmd_valid = user_cmd_valid;
            user_cmd_ready  = issue_cmd_ready;
        end
    end

    // refresh interval and pending flag
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ref_cnt   <= '0;
            ref_pend  <= 1'b0;
            user_hold <= 1'b0;
        end
        else
        begin
            if (init_done)
            begin
                if (int'(ref_cnt) == REF_P - 1)
                begin
                    ref_cnt  <= '0;
                    ref_pend <= 1'b1; // expiry wins over a same-cycle clear
                end
                else
                begin
                    ref_cnt <= ref_cnt + 1'b1;
                    if (ref_xfer)
                        ref_pend <= 1'b0;
                end
            end
            user_hold <= init_done & ~sel_ref & user_cmd_valid & ~issue_cmd_ready;
        end
    end

    // no user grant while the init sequence still has the bus
    a_user_after_init: assert property (
        @(posedge clk) disable iff (!rst_n)
        user_cmd_valid && user_cmd_ready |-> init_done && !init_cmd_valid
    );

endmodule

// ==== hdl/sdram_ctrl_top.sv ====
`timescale 1ns/10ps
// sdram controller command path with init generator, scheduler and pin issue stage
module sdram_ctrl_top #(
    parameter real    CLK_PERIOD       = 7.0,      // ns
    parameter real    INIT_PAUSE       = 250000.0, // ns
    parameter integer BURST_LEN        = -1,       // 1, 2, 4, 8 or -1 full page
    parameter integer CAS_LATENCY      = 2,
    parameter integer AUTO_RFS_N       = 2,
    parameter real    REFRESH_INTERVAL = 7800.0    // ns
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  sdram_cmd_pkg::sdram_cmd_t user_cmd,
    input  logic                      user_cmd_valid,
    output logic                      user_cmd_ready,
    output logic                      init_done,
    output logic                      sdram_cs_n,
    output logic                      sdram_ras_n,
    output logic                      sdram_cas_n,
    output logic                      sdram_we_n,
    output logic [1:0]                sdram_ba,
    output logic [15:0]               sdram_addr
);
    import sdram_cmd_pkg::*;

    sdram_cmd_t init_cmd;  // generator to scheduler
    logic       init_cmd_valid;
    logic       init_cmd_ready;
    sdram_cmd_t issue_cmd; // scheduler to issue stage
    logic       issue_cmd_valid;
    logic       issue_cmd_ready;

    sdram_init_cmd_gen #(
        .CLK_PERIOD (CLK_PERIOD),
        .INIT_PAUSE (INIT_PAUSE),
        .BURST_LEN  (BURST_LEN),
        .CAS_LATENCY(CAS_LATENCY),
        .AUTO_RFS_N (AUTO_RFS_N)
    ) init_gen_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .init_done     (init_done),
        .init_cmd      (init_cmd),
        .init_cmd_valid(init_cmd_valid),
        .init_cmd_ready(init_cmd_ready)
    );

    sdram_cmd_sched #(
        .CLK_PERIOD      (CLK_PERIOD),
        .REFRESH_INTERVAL(REFRESH_INTERVAL)
    ) sched_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .init_done      (init_done),
        .init_cmd       (init_cmd),
        .init_cmd_valid (init_cmd_valid),
        .init_cmd_ready (init_cmd_ready),
        .user_cmd       (user_cmd),
        .user_cmd_valid (user_cmd_valid),
        .user_cmd_ready (user_cmd_ready),
        .issue_cmd      (issue_cmd),
        .issue_cmd_valid(issue_cmd_valid),
        .issue_cmd_ready(issue_cmd_ready)
    );

    sdram_cmd_issue #(
        .CLK_PERIOD(CLK_PERIOD)
    ) issue_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_cmd      (issue_cmd),
        .issue_cmd_valid(issue_cmd_valid),
        .issue_cmd_ready(issue_cmd_ready),
        .sdram_cs_n     (sdram_cs_n),
        .sdram_ras_n    (sdram_ras_n),
        .sdram_cas_n    (sdram_cas_n),
        .sdram_we_n     (sdram_we_n),
        .sdram_ba       (sdram_ba),
        .sdram_addr     (sdram_addr)
    );

endmodule

// ==== hdl/sdram_init_cmd_gen.sv ====
`timescale 1ns/10ps
// sdram power-up sequencer that waits the initial pause and streams the init commands
module sdram_init_cmd_gen #(
    parameter real    CLK_PERIOD  = 7.0,      // ns
    parameter real    INIT_PAUSE  = 250000.0, // ns
    parameter integer BURST_LEN   = -1,       // 1, 2, 4, 8 or -1 for full page
    parameter integer CAS_LATENCY = 2,        // 2 or 3
    parameter integer AUTO_RFS_N  = 2         // refreshes at the end of init
) (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic                      init_done,
    output sdram_cmd_pkg::sdram_cmd_t init_cmd,
    output logic                      init_cmd_valid,
    input  logic                      init_cmd_ready
);
    import sdram_cmd_pkg::*;

    localparam int RST_WAIT_P = ns_to_cycles(INIT_PAUSE, CLK_PERIOD); // pause in cycles
    localparam int ITEM_N     = 6 + AUTO_RFS_N; // pre, mrs, 4 nop, refreshes
    localparam int PAUSE_W    = $clog2(RST_WAIT_P + 1);
    localparam int IDX_W      = $clog2(ITEM_N);

    // mode register field encodings
    localparam logic [2:0] CL_CODE = (CAS_LATENCY == 3) ? 3'b011 : 3'b010;
    localparam logic [2:0] BL_CODE = (BURST_LEN == 1) ? 3'b000 :
                                     (BURST_LEN == 2) ? 3'b001 :
                                     (BURST_LEN == 4) ? 3'b010 :
                                     (BURST_LEN == 8) ? 3'b011 :
                                                        3'b111; // full page

    logic [PAUSE_W-1:0] pause_cnt;  // cycles since reset release
    logic               rst_stable; // pause over
    logic [IDX_W-1:0]   item_idx;   // position in the init sequence
    logic               last_item;
    logic               xfer;

    assign xfer      = init_cmd_valid & init_cmd_ready;
    assign last_item = (int'(item_idx) == ITEM_N - 1);

    // power-up pause
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pause_cnt  <= '0;
            rst_stable <= 1'b0;
        end
        else if (!rst_stable)
        begin
            pause_cnt  <= pause_cnt + 1'b1;
            rst_stable <= (int'(pause_cnt) == RST_WAIT_P - 1); // stable after P edges
        end
    end

    // sequence walk, valid and done
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            item_idx       <= '0;
            init_cmd_valid <= 1'b0;
            init_done      <= 1'b0;
        end
        else
        begin
            if (xfer && !last_item)
                item_idx <= item_idx + 1'b1; // next item shows up next cycle

            if (!init_cmd_valid)
                init_cmd_valid <= rst_stable & ~init_done; // first raise once paused
            else if (xfer && last_item)
                init_cmd_valid <= 1'b0; // stream finished

            if (xfer && last_item)
                init_done <= 1'b1;
        end
    end

    // item decode
    always_comb
    begin
        init_cmd      = '0;
        init_cmd.code = NOP; // slots 2..5
        if (item_idx == '0)
        begin
            init_cmd.code            = PRECHARGE;
            init_cmd.addr.row_col[10] = 1'b1; // all banks
        end
        else if (int'(item_idx) == 1)
        begin
            init_cmd.code                    = MR_SET;
            init_cmd.addr.mode.wr_burst_mode = 1'b0; // burst writes
            init_cmd.addr.mode.op_mode       = 2'b00;
            init_cmd.addr.mode.cas_latency   = CL_CODE;
            init_cmd.addr.mode.burst_type    = 1'b0; // sequential
            init_cmd.addr.mode.burst_len     = BL_CODE;
        end
        else if (int'(item_idx) >= 6)
            init_cmd.code = AUTO_REFRESH;
    end

    // valid may only come up once the full pause has been counted
    a_valid_after_pause: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(init_cmd_valid) |-> $past(rst_stable) && int'($past(pause_cnt)) == RST_WAIT_P
    );

    // held command stays put until taken downstream
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        init_cmd_valid && !init_cmd_ready |=> init_cmd_valid && $stable(init_cmd)
    );

endmodule

// ==== sdram_ctrl_top.f ====
hdl/sdram_cmd_pkg.sv
hdl/sdram_init_cmd_gen.sv
hdl/sdram_cmd_sched.sv
hdl/sdram_cmd_issue.sv
hdl/sdram_ctrl_top.sv
testbench/tb_sdram_ctrl_top.sv

// ==== testbench/tb_sdram_ctrl_top.sv ====
`timescale 1ns/10ps
// testbench for the sdram command path covering reset, init order, gaps, user traffic, refresh
module tb_sdram_ctrl_top;
    import sdram_cmd_pkg::*;

    localparam real    CLK_PERIOD       = 100.0; // ns
    localparam real    INIT_PAUSE       = 2000.0;
    localparam integer BURST_LEN        = 4;
    localparam integer CAS_LATENCY      = 2;
    localparam integer AUTO_RFS_N       = 2;
    localparam real    REFRESH_INTERVAL = 6000.0;

    // one command seen on the pins
    typedef struct packed {
        logic [31:0]     cycle;
        sdram_cmd_code_e code;
        logic [1:0]      ba;
        logic [15:0]     addr;
    } pin_rec_t;

    logic        clk;
    logic        rst_n;
    sdram_cmd_t  user_cmd;
    logic        user_cmd_valid;
    logic        user_cmd_ready;
    logic        init_done;
    logic        sdram_cs_n;
    logic        sdram_ras_n;
    logic        sdram_cas_n;
    logic        sdram_we_n;
    logic [1:0]  sdram_ba;
    logic [15:0] sdram_addr;

    pin_rec_t    mon_q[$]; // every pin command in order
    pin_rec_t    mon_rec;
    logic [31:0] rng = 32'd50; // xorshift state
    int          cyc = 0;      // rising edges so far
    int          err_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          rst_wait_p;   // pause in cycles
    int          ref_cyc;      // refresh interval in cycles
    int          max_gap;      // largest command gap in cycles
    int          max_cycles;   // run limit
    int          done_cyc;     // cycle where init_done was first seen

    sdram_ctrl_top #(
        .CLK_PERIOD      (CLK_PERIOD),
        .INIT_PAUSE      (INIT_PAUSE),
        .BURST_LEN       (BURST_LEN),
        .CAS_LATENCY     (CAS_LATENCY),
        .AUTO_RFS_N      (AUTO_RFS_N),
        .REFRESH_INTERVAL(REFRESH_INTERVAL)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .user_cmd      (user_cmd),
        .user_cmd_valid(user_cmd_valid),
        .user_cmd_ready(user_cmd_ready),
        .init_done     (init_done),
        .sdram_cs_n    (sdram_cs_n),
        .sdram_ras_n   (sdram_ras_n),
        .sdram_cas_n   (sdram_cas_n),
        .sdram_we_n    (sdram_we_n),
        .sdram_ba      (sdram_ba),
        .sdram_addr    (sdram_addr)
    );

    always #(CLK_PERIOD / 2.0) clk = ~clk;

    // cycle count and run limit
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles)
        begin
            $display("run stopped after %0d cycles, a test never finished", cyc);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // pin monitor, sampled mid-cycle where pins are settled
    always @(negedge clk)
    begin
        if (rst_n === 1'b1 && sdram_cs_n === 1'b0)
        begin
            mon_rec.cycle = 32'(cyc);
            mon_rec.code  = pins_to_code(sdram_ras_n, sdram_cas_n, sdram_we_n);
            mon_rec.ba    = sdram_ba;
            mon_rec.addr  = sdram_addr;
            mon_q.push_back(mon_rec);
        end
    end

    // ceiling of t over p
    function automatic int cycles_ceil(input real t_ns, input real p_ns);
        int n;
        n = $rtoi(t_ns / p_ns); // truncates
        if (real'(n) * p_ns < t_ns)
            n = n + 1;
        return n;
    endfunction

    // minimum spacing after a command, never below one slot
    function automatic int gap_cycles(input sdram_cmd_code_e code);
        real t;
        int  n;
        case (code)
            PRECHARGE:    t = T_RP_NS;
            MR_SET:       t = T_MRD_NS;
            AUTO_REFRESH: t = T_RFC_NS;
            default:      t = T_RCD_NS;
        endcase
        n = cycles_ceil(t, CLK_PERIOD);
        return (n < 1) ? 1 : n;
    endfunction

    // jedec truth table, ras cas we
    function automatic sdram_cmd_code_e pins_to_code(input logic ras, input logic cas,
                                                     input logic we);
        case ({ras, cas, we})
            3'b011:  return ACTIVE;
            3'b101:  return READ;
            3'b100:  return WRITE;
            3'b010:  return PRECHARGE;
            3'b001:  return AUTO_REFRESH;
            3'b000:  return MR_SET;
            default: return NOP;
        endcase
    endfunction

    // expected mode register word
    function automatic logic [15:0] mode_word(input int bl, input int cl);
        sdram_mode_reg_t m;
        m             = '0; // sequential, programmed burst, standard op
        m.cas_latency = 3'(cl);
        case (bl)
            1:       m.burst_len = 3'b000;
            2:       m.burst_len = 3'b001;
            4:       m.burst_len = 3'b010;
            8:       m.burst_len = 3'b011;
            default: m.burst_len = 3'b111; // full page
        endcase
        return m;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic require(input bit ok, input string what);
        assert (ok)
        else
        begin
            $display("Failure at time %0t: %s", $time, what);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before)
            $display("test %s passed", name);
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    // to the drive point, 10 ns after the rising edge
    task automatic advance();
        @(posedge clk);
        #10;
    endtask

    task automatic make_user_cmd(output sdram_cmd_t c);
        rng              = xorshift32(rng);
        c                = '0;
        c.ba             = rng[3:2];
        c.addr.row_col   = rng[19:4];
        case (rng[1:0])
            2'd0:    c.code = ACTIVE;
            2'd1:    c.code = WRITE;
            2'd2:    c.code = READ;
            default: c.code = PRECHARGE;
        endcase
    endtask

    // hold one user command until it is taken, counting refused cycles
    task automatic send_user(input sdram_cmd_t c, output int stalls);
        bit taken;
        stalls         = 0;
        taken          = 1'b0;
        user_cmd       = c;
        user_cmd_valid = 1'b1;
        while (!taken)
        begin
            #1; // ready settled for the coming edge
            if (user_cmd_ready === 1'b1)
                taken = 1'b1;
            else
                stalls++;
            advance();
        end
    endtask

    task automatic wait_pins(input int n, input int limit);
        int k;
        k = 0;
        while (mon_q.size() < n && k < limit)
        begin
            @(negedge clk);
            #1;
            k++;
        end
        require(mon_q.size() >= n, "expected pin commands did not appear");
    endtask

    task automatic compare_fields(input int idx, input sdram_cmd_t c);
        compare_value($sformatf("code of pin command %0d", idx), 32'(mon_q[idx].code),
                      32'(c.code));
        compare_value($sformatf("sdram_ba of pin command %0d", idx), 32'(mon_q[idx].ba),
                      32'(c.ba));
        compare_value($sformatf("sdram_addr of pin command %0d", idx), 32'(mon_q[idx].addr),
                      32'(c.addr.row_col));
    endtask

    task automatic reset_state_test();
        int e0;
        e0    = err_cnt;
        rst_n = 1'b0;
        repeat (3)
        begin
            advance();
            compare_value("sdram_cs_n", 32'(sdram_cs_n), 32'd1);
            compare_value("user_cmd_ready", 32'(user_cmd_ready), 32'd0);
            compare_value("init_done", 32'(init_done), 32'd0);
        end
        rst_n = 1'b1; // released at the third drive point
        repeat (rst_wait_p)
        begin
            advance();
            compare_value("sdram_cs_n", 32'(sdram_cs_n), 32'd1);
            compare_value("init_done", 32'(init_done), 32'd0);
            require(mon_q.size() == 0, "a pin command appeared during the power-up pause");
        end
        report_test("reset_state", e0);
    endtask

    task automatic init_order_test();
        int e0;
        int k;
        e0 = err_cnt;
        k  = 0;
        while (init_done !== 1'b1 && k < 6 + AUTO_RFS_N + 10)
        begin
            require(user_cmd_ready === 1'b0, "user stream was granted before init_done");
            if (mon_q.size() == 2 && sdram_cs_n === 1'b1)
                compare_value("sdram_addr in a nop slot", 32'(sdram_addr),
                              32'(mode_word(BURST_LEN, CAS_LATENCY))); // nop keeps the pins
            advance();
            k++;
        end
        require(init_done === 1'b1, "init_done never rose");
        done_cyc = cyc;
        @(negedge clk);
        #1;
        compare_value("pin command count", 32'(mon_q.size()), 32'(2 + AUTO_RFS_N));
        if (mon_q.size() >= 2 + AUTO_RFS_N)
        begin
            compare_value("code of pin command 0", 32'(mon_q[0].code), 32'(PRECHARGE));
            compare_value("sdram_addr[10]", 32'(mon_q[0].addr[10]), 32'd1); // all banks
            compare_value("code of pin command 1", 32'(mon_q[1].code), 32'(MR_SET));
            compare_value("sdram_addr", 32'(mon_q[1].addr),
                          32'(mode_word(BURST_LEN, CAS_LATENCY)));
            for (int i = 2; i < 2 + AUTO_RFS_N; i++)
                compare_value($sformatf("code of pin command %0d", i), 32'(mon_q[i].code),
                              32'(AUTO_REFRESH));
            require(mon_q[1 + AUTO_RFS_N].cycle <= 32'(done_cyc),
                    "init_done rose before the last init refresh");
        end
        report_test("init_order", e0);
    endtask

    task automatic user_passthrough_test();
        int         e0;
        int         base;
        int         stalls;
        sdram_cmd_t c;
        sdram_cmd_t sent[$];
        e0   = err_cnt;
        base = mon_q.size();
        advance();
        for (int i = 0; i < 4; i++)
        begin
            make_user_cmd(c);
            sent.push_back(c);
            send_user(c, stalls); // back to back
        end
        user_cmd_valid = 1'b0;
        wait_pins(base + 4, 10);
        if (mon_q.size() >= base + 4)
            for (int i = 0; i < 4; i++)
                compare_fields(base + i, sent[i]);
        report_test("user_passthrough", e0);
    endtask

    task automatic periodic_refresh_test();
        int         e0;
        int         base;
        int         stalls;
        int         held_idx;
        int         ref_idx;
        int         n;
        sdram_cmd_t c;
        sdram_cmd_t sent[$];
        e0       = err_cnt;
        base     = mon_q.size();
        held_idx = -1;
        n        = 0;
        while (cyc < done_cyc + ref_cyc - 3)
            advance();
        // user traffic across the refresh expiry, one more after the held one
        while ((held_idx < 0 || n < held_idx + 2) && n < 2 * ref_cyc)
        begin
            make_user_cmd(c);
            sent.push_back(c);
            send_user(c, stalls);
            if (stalls > 0 && held_idx < 0)
                held_idx = n;
            n++;
        end
        user_cmd_valid = 1'b0;
        require(held_idx >= 0, "no user command was held back by a refresh");
        wait_pins(base + n + 1, 10);
        if (held_idx >= 0 && mon_q.size() >= base + n + 1)
        begin
            ref_idx = base + held_idx; // refresh goes just before the held command
            for (int i = 0; i < held_idx; i++)
                compare_fields(base + i, sent[i]);
            compare_value("code of refresh slot", 32'(mon_q[ref_idx].code), 32'(AUTO_REFRESH));
            require(mon_q[ref_idx].cycle <= 32'(done_cyc + ref_cyc + max_gap),
                    "first periodic refresh came too late");
            for (int i = held_idx; i < n; i++)
                compare_fields(base + i + 1, sent[i]);
        end
        report_test("periodic_refresh", e0);
    endtask

    // spacing over every command recorded in the run
    task automatic gap_test();
        int e0;
        e0 = err_cnt;
        for (int i = 1; i < mon_q.size(); i++)
            require(mon_q[i].cycle - mon_q[i - 1].cycle >=
                    32'(gap_cycles(mon_q[i - 1].code)),
                    $sformatf("commands at cycles %0d and %0d are closer than the minimum gap",
                              mon_q[i - 1].cycle, mon_q[i].cycle));
        report_test("gaps", e0);
    endtask

    initial
    begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        user_cmd       = '0;
        user_cmd_valid = 1'b0;
        done_cyc       = 0;
        rst_wait_p     = cycles_ceil(INIT_PAUSE, CLK_PERIOD);
        ref_cyc        = cycles_ceil(REFRESH_INTERVAL, CLK_PERIOD);
        max_gap        = gap_cycles(PRECHARGE);
        if (gap_cycles(MR_SET) > max_gap)
            max_gap = gap_cycles(MR_SET);
        if (gap_cycles(AUTO_REFRESH) > max_gap)
            max_gap = gap_cycles(AUTO_REFRESH);
        if (gap_cycles(ACTIVE) > max_gap)
            max_gap = gap_cycles(ACTIVE);
        // pause, init items, two refresh intervals and slack, ten times over
        max_cycles = 10 * (rst_wait_p + 6 + AUTO_RFS_N + 2 * ref_cyc + 52);

        reset_state_test();
        init_order_test();
        user_passthrough_test();
        periodic_refresh_test();
        gap_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
